// ==== hdl/buf_geom_pkg.sv ====
package buf_geom_pkg;

    // sized for a 2048-page buffer
    localparam int MAX_PAGE_BITS = 11;
    localparam int PAGE_WORDS    = 8;

    typedef logic [MAX_PAGE_BITS-1:0] page_idx_t;
    typedef logic [2:0]               word_idx_t;

    // next link, top bit clear
    typedef struct packed {
        logic      is_tail;
        logic [3:0] rsvd;
        page_idx_t next_page;
    } next_link_t;

    // tail descriptor, top bit set
    typedef struct packed {
        logic       is_tail;
        logic [11:0] rsvd;
        word_idx_t  last_word;
    } tail_desc_t;

    // one link table entry, decoded by its top bit
    typedef union packed {
        next_link_t link;
        tail_desc_t tail;
    } link_entry_t;

endpackage

// ==== hdl/ecc_pkg.sv ====
package ecc_pkg;

    // one packet word
    typedef logic [15:0] data_word_t;

    // page code is the xor of every byte in the page
    // words past the end of a packet count as zero
    typedef logic [7:0] ecc_code_t;

endpackage

// ==== hdl/free_page_list.sv ====
`timescale 1ns/1ps

module free_page_list #(
    parameter int NUM_PAGES = 64
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    alloc,
    output buf_geom_pkg::page_idx_t free_page,
    input  logic                    release_vld,
    input  buf_geom_pkg::page_idx_t release_page
);
    import buf_geom_pkg::*;

    localparam int PTR_BITS = $clog2(NUM_PAGES);

    page_idx_t           recycle_q [NUM_PAGES];
    page_idx_t           fresh_cnt;
    logic                fresh_left;
    logic [PTR_BITS-1:0] q_head;
    logic [PTR_BITS-1:0] q_tail;
    logic [PTR_BITS:0]   q_cnt;
    logic                take_queue;
    logic                list_empty;

    function automatic logic [PTR_BITS-1:0] ptr_next(input logic [PTR_BITS-1:0] p);
        return (p == PTR_BITS'(NUM_PAGES - 1)) ? '0 : p + 1'b1;
    endfunction

    // never-used pages first, counting down
    assign free_page  = fresh_left ? fresh_cnt : recycle_q[q_head];
    assign take_queue = alloc && !fresh_left;
    assign list_empty = !fresh_left && (q_cnt == '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fresh_cnt  <= page_idx_t'(NUM_PAGES - 1);
            fresh_left <= 1'b1;
            q_head     <= '0;
            q_tail     <= '0;
            q_cnt      <= '0;
        end else begin
            if (alloc && fresh_left) begin
                fresh_cnt <= fresh_cnt - 1'b1;
                if (fresh_cnt == '0) begin
                    fresh_left <= 1'b0;
                end
            end
            if (take_queue) begin
                q_head <= ptr_next(q_head);
            end
            if (release_vld) begin
                q_tail <= ptr_next(q_tail);
            end
            case ({release_vld, take_queue})
                2'b10:   q_cnt <= q_cnt + 1'b1;
                2'b01:   q_cnt <= q_cnt - 1'b1;
                default: q_cnt <= q_cnt;
            endcase
        end
    end

    // recycled pages queue
    always_ff @(posedge clk) begin
        if (release_vld) begin
            recycle_q[q_tail] <= release_page;
        end
    end

    a_no_alloc_empty: assert property (@(posedge clk) disable iff (!rst_n)
        alloc |-> !list_empty)
        else $error("free_page_list: alloc while empty");

    a_no_overfill: assert property (@(posedge clk) disable iff (!rst_n)
        release_vld |-> (q_cnt < NUM_PAGES))
        else $error("free_page_list: release into full queue");

endmodule

// ==== hdl/packet_buffer_top.sv ====
`timescale 1ns/1ps

module packet_buffer_top #(
    parameter int NUM_PAGES = 64
) (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 in_vld,
    input  ecc_pkg::data_word_t                  in_data,
    input  logic                                 in_eop,
    input  logic                                 rd_req,
    input  buf_geom_pkg::page_idx_t              rd_head,
    output logic                                 wr_done,
    output buf_geom_pkg::page_idx_t              wr_head,
    output logic [buf_geom_pkg::MAX_PAGE_BITS:0] wr_pages,
    output logic                                 out_vld,
    output ecc_pkg::data_word_t                  out_data,
    output logic                                 out_eop,
    output logic                                 page_code_vld,
    output ecc_pkg::ecc_code_t                   page_code,
    output logic                                 rd_busy
);
    import buf_geom_pkg::*;
    import ecc_pkg::*;

    logic                     alloc;
    page_idx_t                free_page;
    logic                     release_vld;
    page_idx_t                release_page;
    logic                     data_we;
    logic [MAX_PAGE_BITS+2:0] data_waddr;
    logic [MAX_PAGE_BITS+2:0] data_raddr;
    data_word_t               data_wdata;
    data_word_t               data_rdata;
    logic                     link_we;
    page_idx_t                link_waddr;
    page_idx_t                link_raddr;
    link_entry_t              link_wdata;
    link_entry_t              link_rdata;
    logic                     code_we;
    page_idx_t                code_waddr;
    page_idx_t                code_raddr;
    ecc_code_t                code_wdata;
    ecc_code_t                code_rdata;

    packet_writer #(.NUM_PAGES(NUM_PAGES)) u_writer (
        .clk, .rst_n, .in_vld, .in_data, .in_eop, .alloc, .free_page,
        .data_we, .data_waddr, .data_wdata, .link_we, .link_waddr, .link_wdata,
        .code_we, .code_waddr, .code_wdata, .wr_done, .wr_head, .wr_pages
    );

    packet_reader u_reader (
        .clk, .rst_n, .rd_req, .rd_head, .data_raddr, .data_rdata,
        .link_raddr, .link_rdata, .code_raddr, .code_rdata, .release_vld, .release_page,
        .out_vld, .out_data, .out_eop, .page_code_vld, .page_code, .rd_busy
    );

    free_page_list #(.NUM_PAGES(NUM_PAGES)) u_free_list (
        .clk, .rst_n, .alloc, .free_page, .release_vld, .release_page
    );

    page_store #(.NUM_PAGES(NUM_PAGES)) u_store (
        .clk, .rst_n,
        .data_we, .data_waddr, .data_wdata, .data_raddr, .data_rdata,
        .link_we, .link_waddr, .link_wdata, .link_raddr, .link_rdata,
        .code_we, .code_waddr, .code_wdata, .code_raddr, .code_rdata
    );

endmodule

// ==== hdl/packet_reader.sv ====
`timescale 1ns/1ps

module packet_reader (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   rd_req,
    input  buf_geom_pkg::page_idx_t                rd_head,
    output logic [buf_geom_pkg::MAX_PAGE_BITS+2:0] data_raddr,
    input  ecc_pkg::data_word_t                    data_rdata,
    output buf_geom_pkg::page_idx_t                link_raddr,
    input  buf_geom_pkg::link_entry_t              link_rdata,
    output buf_geom_pkg::page_idx_t                code_raddr,
    input  ecc_pkg::ecc_code_t                     code_rdata,
    output logic                                   release_vld,
    output buf_geom_pkg::page_idx_t                release_page,
    output logic                                   out_vld,
    output ecc_pkg::data_word_t                    out_data,
    output logic                                   out_eop,
    output logic                                   page_code_vld,
    output ecc_pkg::ecc_code_t                     page_code,
    output logic                                   rd_busy
);
    import buf_geom_pkg::*;

    typedef enum logic [2:0] {S_IDLE, S_HDR, S_DEC, S_WORDS, S_DRAIN} rd_state_t;

    rd_state_t state;
    page_idx_t cur_page;
    page_idx_t next_page;
    word_idx_t r_idx;
    word_idx_t last_word;
    logic      last_page;
    logic      page_last_word;

    assign link_raddr     = cur_page;
    assign code_raddr     = cur_page;
    assign data_raddr     = {cur_page, r_idx};
    assign out_data       = data_rdata;
    assign rd_busy        = (state != S_IDLE);
    assign page_last_word = (r_idx == last_word);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state         <= S_IDLE;
            out_vld       <= 1'b0;
            out_eop       <= 1'b0;
            page_code_vld <= 1'b0;
            release_vld   <= 1'b0;
        end else begin
            // store data comes back one cycle after the address
            out_vld       <= (state == S_WORDS);
            out_eop       <= (state == S_WORDS) && last_page && page_last_word;
            page_code_vld <= (state == S_DEC);
            release_vld   <= (state == S_WORDS) && page_last_word;
            case (state)
                S_IDLE: begin
                    if (rd_req) begin
                        state <= S_HDR;
                    end
                end
                S_HDR:   state <= S_DEC;
                S_DEC:   state <= S_WORDS;
                S_WORDS: begin
                    if (page_last_word) begin
                        state <= last_page ? S_DRAIN : S_HDR;
                    end
                end
                // last word still leaving the store
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            S_IDLE: begin
                if (rd_req) begin
                    cur_page <= rd_head;
                end
            end
            S_DEC: begin
                // top bit picks next link or tail descriptor
                page_code <= code_rdata;
                r_idx     <= '0;
                last_page <= link_rdata.tail.is_tail;
                next_page <= link_rdata.link.next_page;
                if (link_rdata.tail.is_tail) begin
                    last_word <= link_rdata.tail.last_word;
                end else begin
                    last_word <= word_idx_t'(PAGE_WORDS - 1);
                end
            end
            S_WORDS: begin
                r_idx        <= r_idx + 1'b1;
                release_page <= cur_page;
                if (page_last_word) begin
                    cur_page <= next_page;
                end
            end
            default: begin
                r_idx <= r_idx;
            end
        endcase
    end

    a_req_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
        rd_req |-> !rd_busy)
        else $error("packet_reader: rd_req during a read");

    // link entry of each page must have clear reserved bits
    a_link_well_formed: assert property (@(posedge clk) disable iff (!rst_n)
        (state == S_DEC) |->
            (link_rdata.tail.is_tail ? (link_rdata.tail.rsvd == '0)
                                     : (link_rdata.link.rsvd == '0)))
        else $error("packet_reader: malformed link entry");

endmodule

// ==== hdl/packet_writer.sv ====
`timescale 1ns/1ps

module packet_writer #(
    parameter int NUM_PAGES = 64
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   in_vld,
    input  ecc_pkg::data_word_t                    in_data,
    input  logic                                   in_eop,
    output logic                                   alloc,
    input  buf_geom_pkg::page_idx_t                free_page,
    output logic                                   data_we,
    output logic [buf_geom_pkg::MAX_PAGE_BITS+2:0] data_waddr,
    output ecc_pkg::data_word_t                    data_wdata,
    output logic                                   link_we,
    output buf_geom_pkg::page_idx_t                link_waddr,
    output buf_geom_pkg::link_entry_t              link_wdata,
    output logic                                   code_we,
    output buf_geom_pkg::page_idx_t                code_waddr,
    output ecc_pkg::ecc_code_t                     code_wdata,
    output logic                                   wr_done,
    output buf_geom_pkg::page_idx_t                wr_head,
    output logic [buf_geom_pkg::MAX_PAGE_BITS:0]   wr_pages
);
    import buf_geom_pkg::*;
    import ecc_pkg::*;

    typedef enum logic [1:0] {S_IDLE, S_FIRST, S_LATER} wr_state_t;

    wr_state_t              state;
    word_idx_t              w_idx;
    word_idx_t              last_idx_d;
    page_idx_t              cur_page;
    page_idx_t              head_page;
    page_idx_t              wr_page;
    logic [MAX_PAGE_BITS:0] pkt_pages;
    data_word_t             page_buf [PAGE_WORDS];
    ecc_code_t              page_code;
    logic                   page_end_d;
    logic                   eop_d;
    link_entry_t            next_entry;
    link_entry_t            tail_entry;

    // a page is taken at word 0 of every page
    assign alloc   = in_vld && (w_idx == '0);
    assign wr_page = alloc ? free_page : cur_page;

    always_comb begin
        next_entry                = '0;
        next_entry.link.next_page = free_page;
        tail_entry                = '0;
        tail_entry.tail.is_tail   = 1'b1;
        tail_entry.tail.last_word = last_idx_d;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= S_IDLE;
        end else if (in_vld) begin
            case (state)
                S_IDLE: begin
                    state <= in_eop ? S_IDLE : S_FIRST;
                end
                S_FIRST: begin
                    if (in_eop) begin
                        state <= S_IDLE;
                    end else if (w_idx == word_idx_t'(PAGE_WORDS - 1)) begin
                        state <= S_LATER;
                    end
                end
                default: begin
                    if (in_eop) begin
                        state <= S_IDLE;
                    end
                end
            endcase
        end
    end

    // word counter restarts at each packet
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            w_idx     <= '0;
            pkt_pages <= '0;
        end else if (in_vld) begin
            w_idx <= in_eop ? '0 : w_idx + 1'b1;
            if (state == S_IDLE) begin
                pkt_pages <= 1;
            end else if (alloc) begin
                pkt_pages <= pkt_pages + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            cur_page <= free_page;
        end
        if (in_vld && state == S_IDLE) begin
            head_page <= free_page;
        end
    end

    // page image for the encoder, zero padded
    always_ff @(posedge clk) begin
        if (in_vld) begin
            if (w_idx == '0) begin
                for (int i = 1; i < PAGE_WORDS; i++) begin
                    page_buf[i] <= '0;
                end
                page_buf[0] <= in_data;
            end else begin
                page_buf[w_idx] <= in_data;
            end
        end
    end

    page_parity_encoder u_encoder (
        .words0 (page_buf[0]),
        .words1 (page_buf[1]),
        .words2 (page_buf[2]),
        .words3 (page_buf[3]),
        .words4 (page_buf[4]),
        .words5 (page_buf[5]),
        .words6 (page_buf[6]),
        .words7 (page_buf[7]),
        .code   (page_code)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            data_we    <= 1'b0;
            page_end_d <= 1'b0;
            eop_d      <= 1'b0;
            wr_done    <= 1'b0;
            code_we    <= 1'b0;
            link_we    <= 1'b0;
        end else begin
            data_we    <= in_vld;
            page_end_d <= in_vld && (in_eop || w_idx == word_idx_t'(PAGE_WORDS - 1));
            eop_d      <= in_vld && in_eop;
            wr_done    <= eop_d;
            code_we    <= page_end_d;
            // next link at a later page start, tail one cycle after eop
            link_we    <= eop_d || (alloc && state == S_LATER);
        end
    end

    always_ff @(posedge clk) begin
        data_waddr <= {wr_page, w_idx};
        data_wdata <= in_data;
        last_idx_d <= w_idx;
        code_waddr <= cur_page;
        code_wdata <= page_code;
        link_waddr <= cur_page;
        link_wdata <= eop_d ? tail_entry : next_entry;
        if (eop_d) begin
            wr_head  <= head_page;
            wr_pages <= pkt_pages;
        end
    end

    // tail write relies on the idle cycle after eop
    a_gap_after_eop: assert property (@(posedge clk) disable iff (!rst_n)
        (in_vld && in_eop) |=> !in_vld)
        else $error("packet_writer: no idle cycle after eop");

    a_pkt_fits: assert property (@(posedge clk) disable iff (!rst_n)
        (alloc && state != S_IDLE) |-> (pkt_pages < NUM_PAGES))
        else $error("packet_writer: packet larger than buffer");

endmodule

// ==== hdl/page_parity_encoder.sv ====
`timescale 1ns/1ps

module page_parity_encoder (
    input  ecc_pkg::data_word_t words0,
    input  ecc_pkg::data_word_t words1,
    input  ecc_pkg::data_word_t words2,
    input  ecc_pkg::data_word_t words3,
    input  ecc_pkg::data_word_t words4,
    input  ecc_pkg::data_word_t words5,
    input  ecc_pkg::data_word_t words6,
    input  ecc_pkg::data_word_t words7,
    output ecc_pkg::ecc_code_t  code
);
    import ecc_pkg::*;

    ecc_code_t fold [8];
    ecc_code_t pair [4];
    ecc_code_t quad [2];

    // high byte against low byte of each word
    assign fold[0] = words0[15:8] ^ words0[7:0];
    assign fold[1] = words1[15:8] ^ words1[7:0];
    assign fold[2] = words2[15:8] ^ words2[7:0];
    assign fold[3] = words3[15:8] ^ words3[7:0];
    assign fold[4] = words4[15:8] ^ words4[7:0];
    assign fold[5] = words5[15:8] ^ words5[7:0];
    assign fold[6] = words6[15:8] ^ words6[7:0];
    assign fold[7] = words7[15:8] ^ words7[7:0];

    // balanced tree over the folded words
    assign pair[0] = fold[0] ^ fold[1];
    assign pair[1] = fold[2] ^ fold[3];
    assign pair[2] = fold[4] ^ fold[5];
    assign pair[3] = fold[6] ^ fold[7];

    assign quad[0] = pair[0] ^ pair[1];
    assign quad[1] = pair[2] ^ pair[3];

    assign code = quad[0] ^ quad[1];

endmodule

// ==== hdl/page_store.sv ====
`timescale 1ns/1ps

module page_store #(
    parameter int NUM_PAGES = 64
) (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  data_we,
    input  logic [buf_geom_pkg::MAX_PAGE_BITS+2:0] data_waddr,
    input  ecc_pkg::data_word_t                   data_wdata,
    input  logic [buf_geom_pkg::MAX_PAGE_BITS+2:0] data_raddr,
    output ecc_pkg::data_word_t                   data_rdata,
    input  logic                                  link_we,
    input  buf_geom_pkg::page_idx_t               link_waddr,
    input  buf_geom_pkg::link_entry_t             link_wdata,
    input  buf_geom_pkg::page_idx_t               link_raddr,
    output buf_geom_pkg::link_entry_t             link_rdata,
    input  logic                                  code_we,
    input  buf_geom_pkg::page_idx_t               code_waddr,
    input  ecc_pkg::ecc_code_t                    code_wdata,
    input  buf_geom_pkg::page_idx_t               code_raddr,
    output ecc_pkg::ecc_code_t                    code_rdata
);
    import buf_geom_pkg::*;
    import ecc_pkg::*;

    localparam int PAGE_BITS = $clog2(NUM_PAGES);
    localparam int DATA_BITS = PAGE_BITS + 3;

    // data address is {page, word}
    data_word_t  data_mem [NUM_PAGES*PAGE_WORDS];
    link_entry_t link_mem [NUM_PAGES];
    ecc_code_t   code_mem [NUM_PAGES];

    always_ff @(posedge clk) begin
        if (data_we) begin
            data_mem[data_waddr[DATA_BITS-1:0]] <= data_wdata;
        end
        data_rdata <= data_mem[data_raddr[DATA_BITS-1:0]];
    end

    always_ff @(posedge clk) begin
        if (link_we) begin
            link_mem[link_waddr[PAGE_BITS-1:0]] <= link_wdata;
        end
        link_rdata <= link_mem[link_raddr[PAGE_BITS-1:0]];
    end

    always_ff @(posedge clk) begin
        if (code_we) begin
            code_mem[code_waddr[PAGE_BITS-1:0]] <= code_wdata;
        end
        code_rdata <= code_mem[code_raddr[PAGE_BITS-1:0]];
    end

    // writer must stay inside the configured buffer
    a_wr_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        (!data_we || data_waddr[MAX_PAGE_BITS+2:3] < NUM_PAGES) &&
        (!link_we || link_waddr < NUM_PAGES) &&
        (!code_we || code_waddr < NUM_PAGES))
        else $error("page_store: write beyond NUM_PAGES");

endmodule

// ==== list.f ====
hdl/buf_geom_pkg.sv
hdl/ecc_pkg.sv
hdl/page_store.sv
hdl/page_parity_encoder.sv
hdl/free_page_list.sv
hdl/packet_writer.sv
hdl/packet_reader.sv
hdl/packet_buffer_top.sv
tb/tb_packet_buffer.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the packet buffer testbench with verilator, run it, then scan the log
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f list.f \
    --top-module tb_packet_buffer -o tb_packet_buffer_sim \
    && ./obj_dir/tb_packet_buffer_sim 2>&1 | tee sim.log \
    || { echo "build or simulation step failed"; exit 1; }
grep -qF '*** FAILED ***' sim.log && { echo "result: fail"; exit 1; } || echo "result: pass"

// ==== tb/packet_tests.dat ====
// columns (hex): packet length, first word, word step, expected page count
// word k is first + k * step, page count is length / 8 rounded up
0001 a5c3 0000 1
0008 1000 0101 1
0009 fff0 0003 2
0028 0001 0001 5
0010 8000 1111 2
0007 00ff ff01 1
0011 1234 0ace 3
0028 beef 0011 5
0018 4000 f00d 3
0028 0000 0107 5
0028 5a5a 0202 5
0028 c001 fffd 5
0028 7e00 0081 5
0028 0f0f 1010 5
0028 dead 0013 5
0028 ffff ffff 5
0028 2468 1357 5
0028 abcd 0400 5
0028 0101 8001 5
0001 4321 0000 1

// ==== tb/tb_packet_buffer.sv ====
`timescale 1ns/1ps

module tb_packet_buffer;
    import buf_geom_pkg::*;
    import ecc_pkg::*;

    localparam int NUM_PAGES = 64;
    localparam int MAX_TESTS = 32;
    localparam int CLK_HALF  = 2;

    logic                   clk;
    logic                   rst_n;
    logic                   in_vld;
    data_word_t             in_data;
    logic                   in_eop;
    logic                   rd_req;
    page_idx_t              rd_head;
    logic                   wr_done;
    page_idx_t              wr_head;
    logic [MAX_PAGE_BITS:0] wr_pages;
    logic                   out_vld;
    data_word_t             out_data;
    logic                   out_eop;
    logic                   page_code_vld;
    ecc_code_t              page_code;
    logic                   rd_busy;

    // four entries per test: length, first word, step, page count
    logic [15:0] test_mem [MAX_TESTS*4];
    // reference free list, countdown pages first, then released pages
    page_idx_t   free_model [$];
    page_idx_t   chain [$];
    int          total_words;
    int          errors;
    int          test_errors;
    int          pass_cnt;
    int          fail_cnt;

    packet_buffer_top #(.NUM_PAGES(NUM_PAGES)) dut0 (
        .clk, .rst_n, .in_vld, .in_data, .in_eop, .rd_req, .rd_head,
        .wr_done, .wr_head, .wr_pages, .out_vld, .out_data, .out_eop,
        .page_code_vld, .page_code, .rd_busy
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    task automatic check_word(input string name, input data_word_t got, input data_word_t exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
            test_errors++;
        end
    endtask

    task automatic check_code(input string name, input ecc_code_t got, input ecc_code_t exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
            test_errors++;
        end
    endtask

    task automatic check_page(input string name, input page_idx_t got, input page_idx_t exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s got %0d expected %0d", $time, name, got, exp);
            test_errors++;
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("Fail at %0t: %s got %0d expected %0d", $time, name, got, exp);
            test_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s got %b expected %b", $time, name, got, exp);
            test_errors++;
        end
    endtask

    function automatic data_word_t word_at(input data_word_t first, input data_word_t step,
                                           input int k);
        return first + data_word_t'(k) * step;
    endfunction

    // xor of both bytes of every word in the page, missing words are zero
    function automatic ecc_code_t expected_code(input data_word_t first, input data_word_t step,
                                                input int len, input int page);
        ecc_code_t  acc;
        data_word_t w;
        acc = '0;
        for (int k = page * PAGE_WORDS; k < (page + 1) * PAGE_WORDS && k < len; k++) begin
            w   = word_at(first, step, k);
            acc = acc ^ w[15:8] ^ w[7:0];
        end
        return acc;
    endfunction

    task automatic write_packet(input int len, input data_word_t first, input data_word_t step,
                                input int exp_pages);
        int        wait_cyc;
        page_idx_t exp_head;
        exp_head = free_model[0];
        chain.delete();
        for (int p = 0; p < exp_pages; p++) begin
            chain.push_back(free_model.pop_front());
        end
        for (int k = 0; k < len; k++) begin
            in_vld  = 1'b1;
            in_data = word_at(first, step, k);
            in_eop  = (k == len - 1);
            @(negedge clk);
        end
        in_vld   = 1'b0;
        in_eop   = 1'b0;
        wait_cyc = 1;
        while (!wr_done && wait_cyc < 8) begin
            @(negedge clk);
            wait_cyc++;
        end
        if (!wr_done) begin
            $display("write of %0d words never raised wr_done", len);
            test_errors++;
        end else begin
            check_count("wr_done latency", wait_cyc, 2);
            check_count("wr_pages", int'(wr_pages), exp_pages);
            check_page("wr_head", wr_head, exp_head);
        end
    endtask

    task automatic read_packet(input int len, input data_word_t first, input data_word_t step,
                               input int exp_pages, input page_idx_t head);
        int   k;
        int   pg;
        int   cyc;
        logic done;
        k    = 0;
        pg   = 0;
        cyc  = 0;
        done = 1'b0;
        check_flag("rd_busy", rd_busy, 1'b0);
        rd_req  = 1'b1;
        rd_head = head;
        @(negedge clk);
        rd_req = 1'b0;
        while (!done && cyc < 20 * len + 40) begin
            if (page_code_vld) begin
                check_code("page_code", page_code, expected_code(first, step, len, pg));
                pg++;
            end
            if (out_vld) begin
                // the page code must lead the page's first word
                if (k % PAGE_WORDS == 0) begin
                    check_count("page codes before word", pg, k / PAGE_WORDS + 1);
                end
                check_word("out_data", out_data, word_at(first, step, k));
                check_flag("out_eop", out_eop, k == len - 1);
                k++;
                done = out_eop;
            end
            @(negedge clk);
            cyc++;
        end
        if (!done) begin
            $display("read from head %0d never ended with out_eop", head);
            test_errors++;
        end else begin
            check_flag("rd_busy after eop", rd_busy, 1'b0);
        end
        check_count("words read", k, len);
        check_count("page codes", pg, exp_pages);
        // pages go back in chain order
        foreach (chain[i]) begin
            free_model.push_back(chain[i]);
        end
    endtask

    initial begin
        int         n;
        int         sum;
        int         len;
        int         pages;
        data_word_t first;
        data_word_t step;
        rst_n    = 1'b0;
        in_vld   = 1'b0;
        in_data  = '0;
        in_eop   = 1'b0;
        rd_req   = 1'b0;
        rd_head  = '0;
        errors   = 0;
        pass_cnt = 0;
        fail_cnt = 0;
        for (int i = 0; i < MAX_TESTS * 4; i++) begin
            test_mem[i] = '0;
        end
        $readmemh("tb/packet_tests.dat", test_mem);
        n   = 0;
        sum = 0;
        while (n < MAX_TESTS && test_mem[4*n] != 0) begin
            sum += int'(test_mem[4*n]);
            n++;
        end
        if (n == 0) begin
            $display("no tests found in tb/packet_tests.dat");
            $display("*** FAILED ***");
            $finish;
        end else begin
            total_words = sum;
            for (int p = NUM_PAGES - 1; p >= 0; p--) begin
                free_model.push_back(page_idx_t'(p));
            end
            repeat (2) @(posedge clk);
            @(negedge clk);
            rst_n = 1'b1;

            test_errors = 0;
            check_flag("rd_busy", rd_busy, 1'b0);
            check_flag("wr_done", wr_done, 1'b0);
            check_flag("out_vld", out_vld, 1'b0);
            check_flag("page_code_vld", page_code_vld, 1'b0);
            errors += test_errors;
            $display("reset state: %0d errors", test_errors);

            for (int t = 0; t < n; t++) begin
                len         = int'(test_mem[4*t]);
                first       = test_mem[4*t+1];
                step        = test_mem[4*t+2];
                pages       = int'(test_mem[4*t+3]);
                test_errors = 0;
                write_packet(len, first, step, pages);
                read_packet(len, first, step, pages, wr_head);
                errors += test_errors;
                if (test_errors == 0) begin
                    pass_cnt++;
                end else begin
                    fail_cnt++;
                end
                $display("test %0d: len %0d pages %0d head %0d, %0d errors",
                         t, len, pages, wr_head, test_errors);
            end
            $display("%0d tests, %0d passed, %0d failed, %0d errors in total",
                     n, pass_cnt, fail_cnt, errors);
            if (errors == 0) begin
                $display("*** PASSED ***");
            end else begin
                $display("*** FAILED ***");
            end
            $finish;
        end
    end

    // budget of 40 cycles per word in the data file
    initial begin
        wait (total_words > 0);
        repeat (40 * total_words) @(posedge clk);
        $display("run did not finish within %0d cycles", 40 * total_words);
        $display("*** FAILED ***");
        $finish;
    end

endmodule
